// File: Makefile
TOP := tb_sample_logger

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sample_logger.f

# Pass only if the run prints the pass message
sim:
	verilator --binary --timing --top-module $(TOP) -f sample_logger.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

// File: sample_logger.f
src/logger_pkg.sv
src/edge_tally.sv
src/bit_sampler.sv
src/record_fifo.sv
src/sample_logger.sv
tb/tb_sample_logger.sv

// File: src/bit_sampler.sv
/* Serial bit sampler */

`default_nettype none

module bit_sampler (
  input  logic                  clk,
  input  logic                  reset_b,
  input  logic                  clear,
  input  logic                  din,
  input  logic                  sample,
  output logic                  byte_valid,
  output logger_pkg::byte_t     byte_data
);

  import logger_pkg::*;

  // Counter value when the last bit of a byte is taken
  localparam logic [BIT_CNT_W-1:0] LAST_BIT = BIT_CNT_W'(BYTE_W - 1);

  byte_t                shift_q;
  logic [BIT_CNT_W-1:0] bit_cnt;
  logic                 take_bit;

  // Clear has priority over a sample in the same cycle
  assign take_bit = sample && !clear;

  // --------------------------------------------------------------------------
  // Shift register
  // --------------------------------------------------------------------------

  // New bits enter at the LSB so the first bit ends at the MSB
  always_ff @(posedge clk) begin
    if (take_bit) begin
      shift_q <= {shift_q[BYTE_W-2:0], din};
    end
  end

  assign byte_data = shift_q;

  // --------------------------------------------------------------------------
  // Bit counter and byte strobe
  // --------------------------------------------------------------------------

  // Counter wraps to 0 after the eighth bit
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      bit_cnt <= '0;
    end else if (clear) begin
      bit_cnt <= '0;
    end else if (take_bit) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // High for one cycle while shift_q holds the finished byte
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= take_bit && (bit_cnt == LAST_BIT);
    end
  end

endmodule

`default_nettype wire

// File: src/edge_tally.sv
/* Line edge tally */

`default_nettype none

module edge_tally (
  input  logic                    clk,
  input  logic                    reset_b,
  input  logic                    clear,
  input  logic                    din,
  input  logic                    restart,
  output logger_pkg::edge_count_t edges
);

  import logger_pkg::*;

  logic        din_q;
  logic        edge_seen;
  edge_count_t count_q;

  // --------------------------------------------------------------------------
  // Edge detector
  // --------------------------------------------------------------------------

  // Delayed copy of the line, zero after reset or clear
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      din_q <= 1'b0;
    end else if (clear) begin
      din_q <= 1'b0;
    end else begin
      din_q <= din;
    end
  end

  // Either direction of change on din
  assign edge_seen = din ^ din_q;

  // --------------------------------------------------------------------------
  // Saturating edge counter
  // --------------------------------------------------------------------------

  // An edge in the restart cycle belongs to the next record
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      count_q <= '0;
    end else if (clear) begin
      count_q <= '0;
    end else if (restart) begin
      count_q <= edge_count_t'(edge_seen);
    end else if (edge_seen && (count_q != edge_count_t'(EDGE_MAX))) begin
      count_q <= count_q + 1'b1;
    end
  end

  // Count recorded along with a finished byte
  assign edges = count_q;

endmodule

`default_nettype wire

// File: src/logger_pkg.sv
/* Sample logger shared types */

`default_nettype none

package logger_pkg;

  // --------------------------------------------------------------------------
  // Sizes
  // --------------------------------------------------------------------------

  // Sampled byte and bit counter
  localparam int BYTE_W    = 8;
  localparam int BIT_CNT_W = 3;

  // Edge count saturates instead of wrapping
  localparam int EDGE_W    = 4;
  localparam int EDGE_MAX  = 15;

  // Record FIFO, count needs one bit more than a pointer
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = 3;
  localparam int COUNT_W    = 4;

  // --------------------------------------------------------------------------
  // Types
  // --------------------------------------------------------------------------

  typedef logic [BYTE_W-1:0]  byte_t;
  typedef logic [EDGE_W-1:0]  edge_count_t;
  typedef logic [COUNT_W-1:0] fifo_count_t;

  // One logged byte with the line activity that preceded it
  typedef struct packed {
    byte_t       data;
    edge_count_t edges;
  } record_t;

  typedef struct packed {
    logic        empty;
    logic        full;
    logic        overflow;
    fifo_count_t count;
  } fifo_status_t;

endpackage

`default_nettype wire

// File: src/record_fifo.sv
/* Record FIFO */

`default_nettype none

module record_fifo (
  input  logic                     clk,
  input  logic                     reset_b,
  input  logic                     clear,
  input  logic                     wr_en,
  input  logic                     rd_en,
  input  logger_pkg::record_t      wr_data,
  output logger_pkg::record_t      rd_data,
  output logger_pkg::fifo_status_t status
);

  import logger_pkg::*;

  record_t              mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0]   wr_ptr;
  logic [FIFO_AW-1:0]   rd_ptr;
  fifo_count_t          count;
  logic                 overflow;
  logic                 full;
  logic                 empty;
  logic                 wr_ok;
  logic                 rd_ok;

  assign full  = (count == COUNT_W'(FIFO_DEPTH));
  assign empty = (count == '0);

  // A write is refused only when full, a read only when empty
  assign wr_ok = wr_en && !full && !clear;
  assign rd_ok = rd_en && !empty && !clear;

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Show-ahead head of queue
  assign rd_data = mem[rd_ptr];

  // --------------------------------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------------------------------

  // Pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else begin
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Sticky until clear, records lost while full are not recoverable
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      overflow <= 1'b0;
    end else if (clear) begin
      overflow <= 1'b0;
    end else if (wr_en && full) begin
      overflow <= 1'b1;
    end
  end

  assign status.empty    = empty;
  assign status.full     = full;
  assign status.overflow = overflow;
  assign status.count    = count;

endmodule

`default_nettype wire

// File: src/sample_logger.sv
/* Serial line sample logger */

`default_nettype none

module sample_logger (
  input  logic                     clk,
  input  logic                     reset_b,
  input  logic                     din,
  input  logic                     sample,
  input  logic                     rd_en,
  input  logic                     clear,
  output logger_pkg::record_t      rd_data,
  output logger_pkg::fifo_status_t status
);

  import logger_pkg::*;

  logic        byte_valid;
  byte_t       byte_data;
  edge_count_t edges;
  record_t     wr_rec;

  // --------------------------------------------------------------------------
  // Side-by-side line monitors
  // --------------------------------------------------------------------------

  // Tally restarts whenever a byte is recorded
  edge_tally edge_tally_inst (
    .clk     (clk),
    .reset_b (reset_b),
    .clear   (clear),
    .din     (din),
    .restart (byte_valid),
    .edges   (edges)
  );

  bit_sampler bit_sampler_inst (
    .clk        (clk),
    .reset_b    (reset_b),
    .clear      (clear),
    .din        (din),
    .sample     (sample),
    .byte_valid (byte_valid),
    .byte_data  (byte_data)
  );

  // --------------------------------------------------------------------------
  // Record storage
  // --------------------------------------------------------------------------

  assign wr_rec.data  = byte_data;
  assign wr_rec.edges = edges;

  record_fifo record_fifo_inst (
    .clk     (clk),
    .reset_b (reset_b),
    .clear   (clear),
    .wr_en   (byte_valid),
    .rd_en   (rd_en),
    .wr_data (wr_rec),
    .rd_data (rd_data),
    .status  (status)
  );

endmodule

`default_nettype wire

// File: tb/sample_logger_stimulus.txt
# I din sample rd_en clear cycles : inputs held for a number of cycles
# S empty full overflow count     : status compared at once, hex
# R data edges                    : head record compared and popped, din held
# After reset
S 1 0 0 0
# Byte A5 first bit at MSB, then an edge in the cycle that records it
I 1 1 0 0 1
I 0 1 0 0 1
I 1 1 0 0 1
I 0 1 0 0 1
I 0 1 0 0 1
I 1 1 0 0 1
I 0 1 0 0 1
I 1 1 0 0 1
S 1 0 0 0
I 0 0 0 0 1
S 0 0 0 1
I 0 1 0 0 8
I 0 0 0 0 1
S 0 0 0 2
R a5 7
R 00 1
S 1 0 0 0
# Sixteen toggles saturate the edge count
I 1 0 0 0 1
I 0 0 0 0 1
I 1 0 0 0 1
I 0 0 0 0 1
I 1 0 0 0 1
I 0 0 0 0 1
I 1 0 0 0 1
I 0 0 0 0 1
I 1 1 0 0 1
I 0 1 0 0 1
I 1 1 0 0 1
I 0 1 0 0 1
I 1 1 0 0 1
I 0 1 0 0 1
I 1 1 0 0 1
I 0 1 0 0 1
R aa f
S 1 0 0 0
# Ten bytes with no reads, the last two are lost
I 1 1 0 0 8
I 0 1 0 0 1
I 1 1 0 0 7
I 0 1 0 0 2
I 1 1 0 0 6
I 0 1 0 0 3
I 1 1 0 0 5
I 0 1 0 0 4
I 1 1 0 0 4
I 0 1 0 0 5
I 1 1 0 0 3
I 0 1 0 0 6
I 1 1 0 0 2
I 0 1 0 0 7
I 1 1 0 0 1
I 0 1 0 0 16
I 0 0 0 0 1
S 0 1 1 8
R ff 1
R 7f 2
R 3f 2
R 1f 2
R 0f 2
R 07 2
R 03 2
R 01 2
S 1 0 1 0
# Clear in the middle of a byte
I 1 1 0 0 3
I 0 0 0 0 1
I 1 1 0 1 1
S 1 0 0 0
I 1 1 0 0 4
I 0 1 0 0 4
R f0 2
S 1 0 0 0

// File: tb/tb_sample_logger.sv
/* Sample logger testbench */

`default_nettype none

module tb_sample_logger;

  import logger_pkg::*;

  localparam string STIM_FILE  = "tb/sample_logger_stimulus.txt";
  localparam int    WAIT_LIMIT = 64;

  logic         clk;
  logic         reset_b;
  logic         din;
  logic         sample;
  logic         rd_en;
  logic         clear;
  record_t      rd_data;
  fifo_status_t status;

  // Stimulus line being applied
  int           line_no;

  sample_logger sample_logger_inst (
    .clk     (clk),
    .reset_b (reset_b),
    .din     (din),
    .sample  (sample),
    .rd_en   (rd_en),
    .clear   (clear),
    .rd_data (rd_data),
    .status  (status)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "Run stopped at stimulus line %0d", line_no);
  endtask

  task automatic check_status(input fifo_status_t expected);
    if (status !== expected) begin
      abort_run($sformatf("FAIL status at line %0d: got 0x%h, expected 0x%h",
                          line_no, status, expected));
    end
  endtask

  task automatic check_record(input record_t expected);
    if (rd_data !== expected) begin
      abort_run($sformatf("FAIL rd_data at line %0d: got 0x%h, expected 0x%h",
                          line_no, rd_data, expected));
    end
  endtask

  // --------------------------------------------------------------------------
  // Drivers
  // --------------------------------------------------------------------------

  // Called 2 units after a rising edge, returns at the same point
  task automatic run_cycles(input logic d, input logic s, input logic r,
                            input logic c, input int cycles);
    din    = d;
    sample = s;
    rd_en  = r;
    clear  = c;
    repeat (cycles) begin
      @(posedge clk);
      #2;
    end
  endtask

  // din holds its level while waiting and popping
  task automatic pop_record(input record_t expected);
    int waited;
    waited = 0;
    sample = 1'b0;
    rd_en  = 1'b0;
    clear  = 1'b0;
    while (status.empty !== 1'b0 && waited < WAIT_LIMIT) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (status.empty !== 1'b0) begin
      abort_run($sformatf("Timeout at line %0d: no record arrived within %0d cycles",
                          line_no, WAIT_LIMIT));
    end else begin
      check_record(expected);
      rd_en = 1'b1;
      @(posedge clk);
      #2;
      rd_en = 1'b0;
    end
  endtask

  task automatic apply_line(input string text);
    byte          kind;
    int           fields;
    int           cycles;
    logic [7:0]   f0;
    logic [7:0]   f1;
    logic [7:0]   f2;
    logic [7:0]   f3;
    fifo_status_t exp_status;
    record_t      exp_record;
    kind   = text.getc(0);
    cycles = 0;
    if (kind == "I") begin
      fields = $sscanf(text, "I %h %h %h %h %d", f0, f1, f2, f3, cycles);
      if (fields != 5 || cycles < 1) begin
        abort_run($sformatf("Malformed input line %0d in the stimulus file", line_no));
      end else begin
        run_cycles(f0[0], f1[0], f2[0], f3[0], cycles);
      end
    end else if (kind == "S") begin
      fields = $sscanf(text, "S %h %h %h %h", f0, f1, f2, f3);
      if (fields != 4) begin
        abort_run($sformatf("Malformed status line %0d in the stimulus file", line_no));
      end else begin
        exp_status.empty    = f0[0];
        exp_status.full     = f1[0];
        exp_status.overflow = f2[0];
        exp_status.count    = f3[COUNT_W-1:0];
        check_status(exp_status);
      end
    end else if (kind == "R") begin
      fields = $sscanf(text, "R %h %h", f0, f1);
      if (fields != 2) begin
        abort_run($sformatf("Malformed record line %0d in the stimulus file", line_no));
      end else begin
        exp_record.data  = f0;
        exp_record.edges = f1[EDGE_W-1:0];
        pop_record(exp_record);
      end
    end else if (kind != "#" && kind != 8'd10 && kind != 8'd13 && kind != 8'd32) begin
      abort_run($sformatf("Unknown line kind at line %0d of the stimulus file", line_no));
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin
    int    fd;
    string text;
    line_no = 0;
    reset_b = 1'b0;
    din     = 1'b0;
    sample  = 1'b0;
    rd_en   = 1'b0;
    clear   = 1'b0;
    repeat (8) begin
      @(posedge clk);
    end
    #2;
    reset_b = 1'b1;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      abort_run("Could not open the stimulus file");
    end else begin
      while ($fgets(text, fd) != 0) begin
        line_no++;
        apply_line(text);
      end
      $fclose(fd);
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
